// File: build.f
common/io_frame_pkg.sv
design/mode_decoder.sv
design/input_sync.sv
design/clock_control.sv
design/imem_loader/imem_loader.sv
design/io_frame.sv
test/tb_clock_gen.sv
test/tb_io_frame.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_frame
RTL_TOP   ?= io_frame
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
RTL_FILES ?= common/io_frame_pkg.sv design/mode_decoder.sv design/input_sync.sv \
	design/clock_control.sv design/imem_loader/imem_loader.sv design/io_frame.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_io_frame.sv
`timescale 1ns/100ps

module tb_io_frame;

	import io_frame_pkg::*;

	localparam int LOAD_BYTES = 8;
	localparam int WAIT_LIMIT = 40;

	// Combinational decoder outputs as one record
	typedef struct packed {
		logic   sclk_low, ssel_low, sin_low;
		saddr_t saddr_low;
		logic   sclk_high, ssel_high, sin_high;
		saddr_t saddr_high;
		logic   reset_pat, reset_patternbuf_low, reset_patternbuf_high;
		byte_t  io_b_out;
		logic   io_b_lsb_oe;
	} routing_t;

	logic       clk_int;
	logic       clock_external;
	logic [1:0] modesel;
	byte_t      io_a_in, io_b_in, core_outputs;
	logic       sout_low, sout_high, pwm_low, pwm_high;
	logic       sclk_low, sclk_high, ssel_low, ssel_high, sin_low, sin_high;
	saddr_t     saddr_low, saddr_high;
	logic       reset_pat, reset_patternbuf_low, reset_patternbuf_high;
	byte_t      io_b_out, core_port_a;
	logic       io_b_lsb_oe, core_pwm_low, core_pwm_high;
	imem_adr_t  imem_write_adr;
	imem_word_t imem_data;
	logic       imem_write, pat_clock_division, clock_out;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	tb_clock_gen u_clock_gen (.clk_int(clk_int));

	io_frame u_dut (.*);

	// External pattern clock with a 40 ns period
	initial begin
		clock_external = 1'b0;
		forever begin
			#20 clock_external = ~clock_external;
		end
	end

	function automatic routing_t expected_routing(input mode_t m, input byte_t a, input byte_t b,
			input logic s_low, input logic s_high, input byte_t core);
		routing_t r;
		logic     debug;
		logic     hold;
		r = '0;
		debug = (m == MODE_DEBUG);
		hold = (m == MODE_RESET) || (m == MODE_MEMLOAD);
		if (debug && !a[6]) begin
			{r.saddr_low, r.sin_low, r.ssel_low, r.sclk_low} = a[5:0];
		end
		if (debug && a[6]) begin
			{r.saddr_high, r.sin_high, r.ssel_high, r.sclk_high} = a[5:0];
		end
		r.io_b_out = debug ? {core[7:5], (a[6] ? s_high : s_low), 4'b1111} : core;
		r.io_b_lsb_oe = (m == MODE_RUN);
		r.reset_pat = hold || (debug && b[2]);
		r.reset_patternbuf_high = hold || (debug && b[1]);
		r.reset_patternbuf_low = hold || (debug && b[0]);
		return r;
	endfunction

	// Loader model shifts left by one byte with the new byte at the bottom
	function automatic logic [SHIFT_W-1:0] shift_in(input logic [SHIFT_W-1:0] sh, input byte_t b);
		return {sh[SHIFT_W-9:0], b};
	endfunction

	function automatic imem_adr_t adr_of(input logic [SHIFT_W-1:0] sh);
		return sh[57:48];
	endfunction

	function automatic imem_word_t data_of(input logic [SHIFT_W-1:0] sh);
		return {sh[46:24], sh[22:0]};
	endfunction

	function automatic logic random_bit();
		return 1'($urandom());
	endfunction

	task automatic note_result(input logic ok, input string what, input logic [63:0] exp_v,
			input logic [63:0] got_v);
		checks++;
		if (!ok) begin
			errors++;
			$display("error at %0t ns: %s expected %0h got %0h", $time, what, exp_v, got_v);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		note_result(got === exp, what, 64'(exp), 64'(got));
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		note_result(got === exp, what, 64'(exp), 64'(got));
	endtask

	task automatic check_saddr(input string what, input saddr_t got, input saddr_t exp);
		note_result(got === exp, what, 64'(exp), 64'(got));
	endtask

	task automatic check_adr(input string what, input imem_adr_t got, input imem_adr_t exp);
		note_result(got === exp, what, 64'(exp), 64'(got));
	endtask

	task automatic check_word(input string what, input imem_word_t got, input imem_word_t exp);
		note_result(got === exp, what, 64'(exp), 64'(got));
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		note_result(got == exp, what, 64'(exp), 64'(got));
	endtask

	task automatic compare_routing(input routing_t exp);
		check_bit("sclk_low", sclk_low, exp.sclk_low);
		check_bit("ssel_low", ssel_low, exp.ssel_low);
		check_bit("sin_low", sin_low, exp.sin_low);
		check_saddr("saddr_low", saddr_low, exp.saddr_low);
		check_bit("sclk_high", sclk_high, exp.sclk_high);
		check_bit("ssel_high", ssel_high, exp.ssel_high);
		check_bit("sin_high", sin_high, exp.sin_high);
		check_saddr("saddr_high", saddr_high, exp.saddr_high);
		check_bit("reset_pat", reset_pat, exp.reset_pat);
		check_bit("reset_patternbuf_low", reset_patternbuf_low, exp.reset_patternbuf_low);
		check_bit("reset_patternbuf_high", reset_patternbuf_high, exp.reset_patternbuf_high);
		check_byte("io_b_out", io_b_out, exp.io_b_out);
		check_bit("io_b_lsb_oe", io_b_lsb_oe, exp.io_b_lsb_oe);
	endtask

	// Pins only move on falling edges and the decoder has settled by the rising edge
	always @(posedge clk_int) begin
		compare_routing(expected_routing(mode_t'(modesel), io_a_in, io_b_in, sout_low, sout_high,
			core_outputs));
	end

	task automatic check_reset_state();
		check_bit("pat_clock_division in reset", pat_clock_division, 1'b1);
		check_bit("clock_out in reset", clock_out, 1'b0);
		check_bit("imem_write in reset", imem_write, 1'b0);
		check_byte("core_port_a in reset", core_port_a, '0);
		check_bit("core_pwm_low in reset", core_pwm_low, 1'b0);
		check_bit("core_pwm_high in reset", core_pwm_high, 1'b0);
		check_adr("imem_write_adr in reset", imem_write_adr, '0);
		check_word("imem_data in reset", imem_data, '0);
	endtask

	task automatic count_edges_to_rise(output int edges);
		logic prev;
		logic rose;
		prev = clock_out;
		rose = 1'b0;
		edges = 0;
		while (!rose && edges < WAIT_LIMIT) begin
			@(negedge clk_int);
			edges++;
			rose = !prev && clock_out;
			prev = clock_out;
		end
		if (!rose) begin
			timeouts++;
			$display("timeout: clock_out did not rise within %0d cycles", WAIT_LIMIT);
		end
	endtask

	// clock_external rises are seen on falling internal edges
	task automatic wait_ext_rises(input int count);
		int   seen;
		int   cycles;
		logic prev;
		seen = 0;
		cycles = 0;
		prev = clock_external;
		while (seen < count && cycles < WAIT_LIMIT) begin
			@(negedge clk_int);
			cycles++;
			if (!prev && clock_external) begin
				seen++;
			end
			prev = clock_external;
		end
		if (seen < count) begin
			timeouts++;
			$display("timeout: clock_external stopped toggling");
		end
	endtask

	task automatic flag_step(input byte_t b_value, input logic exp);
		io_b_in = b_value;
		wait_ext_rises(2);
		check_bit("pat_clock_division", pat_clock_division, exp);
	endtask

	task automatic pulse_load(input byte_t value, input int high_cycles, input int low_cycles);
		io_a_in = value;
		io_b_in[0] = 1'b1;
		repeat (high_cycles) @(negedge clk_int);
		io_b_in[0] = 1'b0;
		repeat (low_cycles) @(negedge clk_int);
	endtask

	initial begin
		logic [SHIFT_W-1:0] shift_model;
		int                 edges;
		byte_t              b;
		void'($urandom(35397));
		modesel = 2'd0;
		// Pins sit high during reset so the synchronisers must be held clear
		io_a_in = 8'hff;
		io_b_in = 8'hff;
		core_outputs = '0;
		sout_low = 1'b0;
		sout_high = 1'b0;
		pwm_low = 1'b1;
		pwm_high = 1'b1;
		shift_model = '0;
		repeat (5) @(negedge clk_int);
		check_reset_state();

		// Divider starts counting when reset mode is left
		modesel = MODE_DEBUG;
		count_edges_to_rise(edges);
		check_count("edges to first clock_out rise", edges, 8);
		count_edges_to_rise(edges);
		check_count("clock_out period", edges, 16);

		repeat (40) begin
			@(negedge clk_int);
			io_a_in = byte_t'($urandom());
			io_b_in = byte_t'($urandom());
			core_outputs = byte_t'($urandom());
			sout_low = random_bit();
			sout_high = random_bit();
		end

		@(negedge clk_int);
		modesel = MODE_MEMLOAD;
		io_b_in = '0;
		repeat (4) @(negedge clk_int);
		for (int i = 0; i < LOAD_BYTES; i++) begin
			b = byte_t'($urandom());
			pulse_load(b, 4 + $urandom_range(2), 4 + $urandom_range(2));
			shift_model = shift_in(shift_model, b);
			check_adr("imem_write_adr", imem_write_adr, adr_of(shift_model));
			check_word("imem_data", imem_data, data_of(shift_model));
		end
		io_b_in[1] = 1'b1;
		repeat (3) @(negedge clk_int);
		check_bit("imem_write high", imem_write, 1'b1);
		check_word("imem_data held on write", imem_data, data_of(shift_model));
		io_b_in[1] = 1'b0;
		repeat (3) @(negedge clk_int);
		check_bit("imem_write low", imem_write, 1'b0);

		// Run mode gates the strobes and pins reach the core through the synchroniser
		modesel = MODE_RUN;
		repeat (16) begin
			io_a_in = byte_t'($urandom());
			io_b_in = byte_t'($urandom());
			core_outputs = byte_t'($urandom());
			pwm_low = random_bit();
			pwm_high = random_bit();
			repeat (3) @(negedge clk_int);
			check_byte("core_port_a", core_port_a, io_a_in);
			check_bit("core_pwm_low", core_pwm_low, pwm_low);
			check_bit("core_pwm_high", core_pwm_high, pwm_high);
			check_bit("imem_write outside load", imem_write, 1'b0);
		end

		modesel = MODE_DEBUG;
		flag_step(8'h08, 1'b1);
		flag_step(8'h00, 1'b0);
		flag_step(8'h08, 1'b1);
		modesel = MODE_RUN;
		flag_step(8'h00, 1'b1);
		modesel = MODE_DEBUG;
		flag_step(8'h00, 1'b0);
		modesel = MODE_RESET;
		@(negedge clk_int);
		check_reset_state();

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk_int
);

	// 8 ns period
	localparam int HALF_PERIOD_NS = 4;

	initial begin
		clk_int = 1'b0;
		forever begin
			#HALF_PERIOD_NS clk_int = ~clk_int;
		end
	end

endmodule

// File: design/io_frame.sv
`timescale 1ns/100ps

module io_frame (
	input  logic                     clk_int,
	input  logic                     clock_external,
	input  logic [1:0]               modesel,
	input  io_frame_pkg::byte_t      io_a_in,
	input  io_frame_pkg::byte_t      io_b_in,
	input  logic                     sout_low,
	input  logic                     sout_high,
	input  logic                     pwm_low,
	input  logic                     pwm_high,
	input  io_frame_pkg::byte_t      core_outputs,
	output logic                     sclk_low,
	output logic                     sclk_high,
	output logic                     ssel_low,
	output logic                     ssel_high,
	output logic                     sin_low,
	output logic                     sin_high,
	output io_frame_pkg::saddr_t     saddr_low,
	output io_frame_pkg::saddr_t     saddr_high,
	output logic                     reset_pat,
	output logic                     reset_patternbuf_low,
	output logic                     reset_patternbuf_high,
	output io_frame_pkg::byte_t      io_b_out,
	output logic                     io_b_lsb_oe,
	output io_frame_pkg::byte_t      core_port_a,
	output logic                     core_pwm_low,
	output logic                     core_pwm_high,
	output io_frame_pkg::imem_adr_t  imem_write_adr,
	output io_frame_pkg::imem_word_t imem_data,
	output logic                     imem_write,
	output logic                     pat_clock_division,
	output logic                     clock_out
);

	import io_frame_pkg::*;

	mode_t mode;
	logic  mode_is_reset;
	logic  load_strobe;
	logic  write_strobe;
	logic  load_strobe_sync;

	mode_decoder u_mode_decoder (
		.modesel               (modesel),
		.io_a_in               (io_a_in),
		.io_b_in               (io_b_in),
		.sout_low              (sout_low),
		.sout_high             (sout_high),
		.core_outputs          (core_outputs),
		.mode                  (mode),
		.mode_is_reset         (mode_is_reset),
		.load_strobe           (load_strobe),
		.write_strobe          (write_strobe),
		.sclk_low              (sclk_low),
		.sclk_high             (sclk_high),
		.ssel_low              (ssel_low),
		.ssel_high             (ssel_high),
		.sin_low               (sin_low),
		.sin_high              (sin_high),
		.saddr_low             (saddr_low),
		.saddr_high            (saddr_high),
		.reset_pat             (reset_pat),
		.reset_patternbuf_low  (reset_patternbuf_low),
		.reset_patternbuf_high (reset_patternbuf_high),
		.io_b_out              (io_b_out),
		.io_b_lsb_oe           (io_b_lsb_oe)
	);

	// Synchronised write strobe goes straight to the memory
	input_sync u_input_sync (
		.clk_int           (clk_int),
		.mode_is_reset     (mode_is_reset),
		.io_a_in           (io_a_in),
		.load_strobe       (load_strobe),
		.write_strobe      (write_strobe),
		.pwm_low           (pwm_low),
		.pwm_high          (pwm_high),
		.port_a_sync       (core_port_a),
		.load_strobe_sync  (load_strobe_sync),
		.write_strobe_sync (imem_write),
		.pwm_low_sync      (core_pwm_low),
		.pwm_high_sync     (core_pwm_high)
	);

	imem_loader u_imem_loader (
		.clk_int          (clk_int),
		.mode_is_reset    (mode_is_reset),
		.port_a_sync      (core_port_a),
		.load_strobe_sync (load_strobe_sync),
		.imem_write_adr   (imem_write_adr),
		.imem_data        (imem_data)
	);

	// b3 requests the slow pattern clock
	clock_control u_clock_control (
		.clk_int            (clk_int),
		.clock_external     (clock_external),
		.mode_is_reset      (mode_is_reset),
		.mode               (mode),
		.div_request        (io_b_in[3]),
		.clock_out          (clock_out),
		.pat_clock_division (pat_clock_division)
	);

endmodule

// File: design/imem_loader/imem_loader.sv
`timescale 1ns/100ps

module imem_loader (
	input  logic                     clk_int,
	input  logic                     mode_is_reset,
	input  io_frame_pkg::byte_t      port_a_sync,
	input  logic                     load_strobe_sync,
	output io_frame_pkg::imem_adr_t  imem_write_adr,
	output io_frame_pkg::imem_word_t imem_data
);

	import io_frame_pkg::*;

	logic               strobe_prev;
	logic               load_edge;
	logic [SHIFT_W-1:0] shifter;

	assign load_edge = load_strobe_sync & ~strobe_prev;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			strobe_prev <= 1'b0;
		end else begin
			strobe_prev <= load_strobe_sync;
		end
	end

	// One byte in per rising strobe edge so the oldest byte ends up on top
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			shifter <= '0;
		end else if (load_edge) begin
			shifter <= {shifter[SHIFT_W-BYTE_W-1:0], port_a_sync};
		end
	end

	assign imem_write_adr = shifter[SHIFT_W-1 -: IMEM_ADR_W];

	// Patterns arrive as 24 bits but memory stores 23
	// so the top bit of each pattern is dropped
	assign imem_data = {shifter[PATTERN_W +: IMEM_HALF_W], shifter[IMEM_HALF_W-1:0]};

	// Without back-pressure each strobe level must last three cycles before it changes
	a_strobe_width : assert property (
		@(posedge clk_int) disable iff (mode_is_reset)
		(load_strobe_sync != $past(load_strobe_sync)) |->
			($past(load_strobe_sync, 2) == $past(load_strobe_sync)) &&
			($past(load_strobe_sync, 3) == $past(load_strobe_sync))
	) else $error("load strobe level held for less than three cycles");

endmodule

// File: design/clock_control.sv
`timescale 1ns/100ps

module clock_control (
	input  logic                clk_int,
	input  logic                clock_external,
	input  logic                mode_is_reset,
	input  io_frame_pkg::mode_t mode,
	input  logic                div_request,
	output logic                clock_out,
	output logic                pat_clock_division
);

	import io_frame_pkg::*;

	logic [CLK_DIV_W-1:0] clk_div;

	// Free-running divide by 16
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			clk_div <= '0;
		end else begin
			clk_div <= clk_div + 1'b1;
		end
	end

	assign clock_out = clk_div[CLK_DIV_W-1];

	// Division flag sits on the external clock
	// Preset in reset mode and updated from b3 only while debugging
	always_ff @(posedge clock_external or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			pat_clock_division <= 1'b1;
		end else if (mode == MODE_DEBUG) begin
			pat_clock_division <= div_request;
		end
	end

endmodule

// File: design/input_sync.sv
`timescale 1ns/100ps

module input_sync (
	input  logic                clk_int,
	input  logic                mode_is_reset,
	input  io_frame_pkg::byte_t io_a_in,
	input  logic                load_strobe,
	input  logic                write_strobe,
	input  logic                pwm_low,
	input  logic                pwm_high,
	output io_frame_pkg::byte_t port_a_sync,
	output logic                load_strobe_sync,
	output logic                write_strobe_sync,
	output logic                pwm_low_sync,
	output logic                pwm_high_sync
);

	import io_frame_pkg::*;

	localparam int SYNC_W = BYTE_W + 4;

	logic [SYNC_W-1:0] async_in;
	logic [SYNC_W-1:0] stage_1;
	logic [SYNC_W-1:0] stage_2;

	assign async_in = {io_a_in, load_strobe, write_strobe, pwm_low, pwm_high};

	// Two flop stages per pin
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			stage_1 <= '0;
			stage_2 <= '0;
		end else begin
			stage_1 <= async_in;
			stage_2 <= stage_1;
		end
	end

	assign {port_a_sync, load_strobe_sync, write_strobe_sync,
		pwm_low_sync, pwm_high_sync} = stage_2;

endmodule

// File: design/mode_decoder.sv
`timescale 1ns/100ps

module mode_decoder (
	input  logic [1:0]           modesel,
	input  io_frame_pkg::byte_t  io_a_in,
	input  io_frame_pkg::byte_t  io_b_in,
	input  logic                 sout_low,
	input  logic                 sout_high,
	input  io_frame_pkg::byte_t  core_outputs,
	output io_frame_pkg::mode_t  mode,
	output logic                 mode_is_reset,
	output logic                 load_strobe,
	output logic                 write_strobe,
	output logic                 sclk_low,
	output logic                 sclk_high,
	output logic                 ssel_low,
	output logic                 ssel_high,
	output logic                 sin_low,
	output logic                 sin_high,
	output io_frame_pkg::saddr_t saddr_low,
	output io_frame_pkg::saddr_t saddr_high,
	output logic                 reset_pat,
	output logic                 reset_patternbuf_low,
	output logic                 reset_patternbuf_high,
	output io_frame_pkg::byte_t  io_b_out,
	output logic                 io_b_lsb_oe
);

	import io_frame_pkg::*;

	logic is_debug;
	logic hold_reset;
	logic sel_high;
	logic sout_sel;

	assign mode = mode_t'(modesel);
	assign mode_is_reset = (mode == MODE_RESET);
	assign is_debug = (mode == MODE_DEBUG);

	// Reset and memory load keep the core and both buffers in reset
	assign hold_reset = (mode == MODE_RESET) || (mode == MODE_MEMLOAD);

	// Strobes are only meaningful while loading the instruction memory
	assign load_strobe = (mode == MODE_MEMLOAD) & io_b_in[0];
	assign write_strobe = (mode == MODE_MEMLOAD) & io_b_in[1];

	// a6 picks the pattern buffer and 1 selects the high one
	assign sel_high = is_debug & io_a_in[6];

	always_comb begin
		sclk_low = is_debug & ~sel_high & io_a_in[0];
		ssel_low = is_debug & ~sel_high & io_a_in[1];
		sin_low = is_debug & ~sel_high & io_a_in[2];
		saddr_low = (is_debug && !sel_high) ? io_a_in[5:3] : '0;
		sclk_high = sel_high & io_a_in[0];
		ssel_high = sel_high & io_a_in[1];
		sin_high = sel_high & io_a_in[2];
		saddr_high = sel_high ? io_a_in[5:3] : '0;
	end

	assign sout_sel = sel_high ? sout_high : sout_low;

	// Lower nibble is driven high in debug since those pins serve as reset inputs then
	assign io_b_out = is_debug ? {core_outputs[7:5], sout_sel, 4'b1111} : core_outputs;
	assign io_b_lsb_oe = (mode == MODE_RUN);

	assign reset_pat = hold_reset | (is_debug & io_b_in[2]);
	assign reset_patternbuf_high = hold_reset | (is_debug & io_b_in[1]);
	assign reset_patternbuf_low = hold_reset | (is_debug & io_b_in[0]);

endmodule

// File: common/io_frame_pkg.sv
package io_frame_pkg;

	// Pad port and core byte width
	localparam int BYTE_W = 8;

	// Debug serial address into a pattern buffer
	localparam int SADDR_W = 3;

	// Instruction memory geometry
	localparam int IMEM_ADR_W = 10;
	localparam int PATTERN_W = 24;
	localparam int IMEM_HALF_W = 23;

	// Loader shifter holds the address plus two shifted-in patterns
	localparam int SHIFT_W = IMEM_ADR_W + 2 * PATTERN_W;

	localparam int CLK_DIV_W = 4;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [SADDR_W-1:0] saddr_t;
	typedef logic [IMEM_ADR_W-1:0] imem_adr_t;

	// Two stored patterns with the high one in the upper half
	typedef logic [2*IMEM_HALF_W-1:0] imem_word_t;

	// Chip mode from the two select pins
	typedef enum logic [1:0] {
		MODE_RESET = 2'd0,
		MODE_DEBUG = 2'd1,
		MODE_RUN = 2'd2,
		MODE_MEMLOAD = 2'd3
	} mode_t;

endpackage
